// File: jp_pkg.sv
package jp_pkg;

    typedef logic [7:0]  pix_t;       // one pixel byte
    typedef logic [63:0] buf_word_t;  // buffer write word, 8 pixels
    typedef logic [1:0]  page_t;      // buffer page number
    typedef logic [11:0] buf_addr_t;  // {page, byte in 1024-byte page}
    typedef logic [12:0] mb_count_t;  // macroblock count minus one

    // converter types, codes match the compressor mode register
    typedef enum logic [2:0] {
        COLOR18 = 3'd0,  // 4:2:0, 18x18 overlapping tiles for de-bayer
        COLOR20 = 3'd1,  // 4:2:0, 20x20 overlapping tiles
        MONO16  = 3'd2,  // 16x16, colour components zeroed later
        JP4     = 3'd3,  // jp4, 16x16 macroblocks
        JP4DIFF = 3'd4,  // jp4 with differences, same geometry
        MONO8   = 3'd7   // plain monochrome, 8x8 macroblocks
    } cmprs_mode_e;

    typedef struct packed {
        logic [5:0] mb_w_m1;      // macroblock width - 1
        logic [5:0] mb_h_m1;      // macroblock height - 1
        logic [4:0] mb_hper;      // horizontal period inside a page
        logic [1:0] tile_width;   // page row stride = 16 << tile_width
        logic [4:0] mb_per_page;  // macroblocks taken from one page
    } mb_geom_t;

    typedef struct packed {
        cmprs_mode_e converter_type;      // selects macroblock geometry
        mb_count_t   n_blocks_in_row_m1;  // macroblocks in a row - 1
        mb_count_t   n_block_rows_m1;     // macroblock rows in a frame - 1
    } frame_cfg_t;

    // macroblock shape and page layout for each converter type
    function automatic mb_geom_t cmprs_geometry(input cmprs_mode_e mode);
        mb_geom_t g;
        case (mode)
            COLOR18: g = '{6'd17, 6'd17, 5'd16, 2'd1, 5'd1};  // 18x18, stride 32
            COLOR20: g = '{6'd19, 6'd19, 5'd16, 2'd1, 5'd1};  // 20x20, stride 32
            MONO8:   g = '{6'd7,  6'd7,  5'd8,  2'd3, 5'd16}; // 8x8, stride 128
            default: g = '{6'd15, 6'd15, 5'd16, 2'd2, 5'd4};  // mono16/jp4/jp4diff, stride 64
        endcase
        return g;
    endfunction

endpackage

// File: chn_rd_buf.sv
`timescale 1ns/1ps

module chn_rd_buf (
    input  logic              xclk,
    input  logic              rst,
    input  logic              wpage_set,     // restart writing at page 0, word 0
    input  logic              page_next,     // advance to next write page
    input  logic              we,            // write one 64-bit word
    input  jp_pkg::buf_word_t data_in,
    input  jp_pkg::buf_addr_t ext_ra,        // byte read address
    input  logic              ext_rd,        // read enable, first stage
    input  logic              ext_regen,     // output register enable, one cycle later
    output jp_pkg::pix_t      ext_data_out
);
    import jp_pkg::*;

    buf_word_t mem [512];   // 4 pages x 128 words
    page_t      wpage;      // page being filled
    logic [6:0] wptr;       // word inside the page
    buf_word_t  rd_word;    // word holding the addressed byte
    pix_t       rd_byte;    // first read stage

    assign rd_word = mem[ext_ra[11:3]];  // 8 bytes per word

    // write port, byte i of a word lands at address word*8+i
    always_ff @(posedge xclk) begin
        if (we) begin
            mem[{wpage, wptr}] <= data_in;
        end
    end

    always_ff @(posedge xclk) begin
        if (rst || wpage_set) begin
            wpage <= '0;
            wptr  <= '0;
        end else if (page_next) begin
            wpage <= wpage + 2'd1;  // wraps over 4 pages
            wptr  <= '0;
        end else if (we) begin
            wptr  <= wptr + 7'd1;
        end
    end

    // two-stage read, byte select then output register
    always_ff @(posedge xclk) begin
        if (ext_rd) begin
            rd_byte <= rd_word[{ext_ra[2:0], 3'b000} +: 8];  // little-endian byte lane
        end
        if (ext_regen) begin
            ext_data_out <= rd_byte;
        end
    end

endmodule

// File: cmprs_macroblock_buf_iface.sv
`timescale 1ns/1ps

module cmprs_macroblock_buf_iface (
    input  logic               xclk,
    input  logic               rst,
    input  logic               frame_en,        // low aborts the frame at once
    input  logic               frame_go,        // start a frame when idle
    input  jp_pkg::frame_cfg_t frame_cfg,
    input  logic               page_ready_chn,  // one full page landed in the buffer
    input  logic               mb_pre_end,      // reader issues last address of a macroblock
    output logic               next_page_chn,   // oldest page is free again
    output logic               mb_pre_start,    // start reading the next macroblock
    output jp_pkg::page_t      start_page,      // page of that macroblock
    output logic [6:0]         macroblock_x,    // left column inside the page
    output logic               frame_busy,
    output logic               frame_done
);
    import jp_pkg::*;

    typedef enum logic [1:0] {
        idle,       // no frame
        wait_page,  // reader free, no ready page yet
        run,        // a macroblock is being read
        finish      // last macroblock issued, frame_done this cycle
    } seq_state_e;

    seq_state_e state;
    mb_geom_t   geom;
    logic [2:0] ready_cnt;    // ready and not yet released pages, 0..4
    mb_count_t  mb_col;       // column of the next macroblock
    mb_count_t  mb_row;       // row of the next macroblock
    logic [4:0] mb_in_page;   // index of the next macroblock inside its page
    logic       rel_pend;     // macroblock in flight closes its page
    logic       last_pend;    // macroblock in flight closes the frame
    logic       last_in_row;
    logic       last_mb;
    logic       last_in_page;
    logic       release_now;
    logic       frame_end_now;
    logic       reader_free;
    logic       page_avail;

    assign geom = cmprs_geometry(frame_cfg.converter_type);

    assign last_in_row  = mb_col == frame_cfg.n_blocks_in_row_m1;
    assign last_mb      = last_in_row && (mb_row == frame_cfg.n_block_rows_m1);
    assign last_in_page = mb_in_page == (geom.mb_per_page - 5'd1);

    assign release_now   = (state == run) && mb_pre_end && rel_pend;
    assign frame_end_now = (state == run) && mb_pre_end && last_pend;

    // reader can take a macroblock now, back-to-back on mb_pre_end
    assign reader_free = (state == wait_page) || ((state == run) && mb_pre_end && !last_pend);
    // a page released this cycle no longer counts
    assign page_avail  = ready_cnt > {2'b00, release_now};

    assign mb_pre_start = frame_en && reader_free && page_avail;

    assign frame_busy = state != idle;
    assign frame_done = state == finish;  // one cycle after last mb_pre_end

    always_ff @(posedge xclk) begin
        if (rst) begin
            state         <= idle;
            ready_cnt     <= '0;
            next_page_chn <= 1'b0;
            rel_pend      <= 1'b0;
            last_pend     <= 1'b0;
            mb_col        <= '0;
            mb_row        <= '0;
            mb_in_page    <= '0;
            start_page    <= '0;
            macroblock_x  <= '0;
        end else if (!frame_en) begin
            state         <= idle;   // abort, counters reloaded on next start
            next_page_chn <= 1'b0;
        end else begin
            next_page_chn <= release_now;  // 1 cycle after releasing mb_pre_end
            ready_cnt     <= ready_cnt + {2'b00, page_ready_chn} - {2'b00, release_now};
            case (state)
                idle: begin
                    if (frame_go) begin
                        state        <= wait_page;
                        ready_cnt    <= {2'b00, page_ready_chn};  // new frame, fresh count
                        mb_col       <= '0;
                        mb_row       <= '0;
                        mb_in_page   <= '0;
                        start_page   <= '0;
                        macroblock_x <= '0;
                    end
                end
                wait_page: begin
                    if (mb_pre_start) begin
                        state <= run;
                    end
                end
                run: begin
                    if (frame_end_now) begin
                        state <= finish;
                    end else if (mb_pre_end && !mb_pre_start) begin
                        state <= wait_page;  // back-pressure, no page ready
                    end
                end
                finish: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
            if (mb_pre_start) begin
                rel_pend  <= last_in_page || last_mb;  // page closes after this one
                last_pend <= last_mb;
                if (last_in_row) begin
                    mb_col <= '0;
                    mb_row <= mb_row + 13'd1;
                end else begin
                    mb_col <= mb_col + 13'd1;
                end
                if (last_in_page) begin
                    mb_in_page   <= '0;
                    start_page   <= start_page + 2'd1;  // pages used in order
                    macroblock_x <= '0;
                end else begin
                    mb_in_page   <= mb_in_page + 5'd1;
                    macroblock_x <= macroblock_x + {2'b00, geom.mb_hper};
                end
            end
        end
    end

endmodule

// File: cmprs_pixel_buf_iface.sv
`timescale 1ns/1ps

module cmprs_pixel_buf_iface #(
    parameter int BUF_EXTRA_LATENCY = 0  // register stages after buffer output, 0 or 1
) (
    input  logic               xclk,
    input  logic               rst,
    input  logic               frame_en,       // low kills reads and strobes
    input  jp_pkg::frame_cfg_t frame_cfg,
    input  logic               mb_pre_start,   // next cycle issues first address
    input  jp_pkg::page_t      start_page,
    input  logic [6:0]         macroblock_x,
    input  jp_pkg::pix_t       buf_di,         // buffer data, 2 cycles after address
    output jp_pkg::buf_addr_t  buf_ra,
    output logic [1:0]         buf_rd,         // {regen, re}
    output logic               mb_pre_end,     // last address of this macroblock
    output jp_pkg::pix_t       data_out,       // pixels in scanline order
    output logic               pre_first_out,  // one cycle before first valid byte
    output logic               data_valid
);
    import jp_pkg::*;

    typedef struct packed {
        logic valid;  // address was issued
        logic first;  // first address of a macroblock
    } strb_t;

    localparam int PIPE_LEN = BUF_EXTRA_LATENCY + 2;  // buffer read plus extra stages

    mb_geom_t             geom;
    logic [9:0]           stride;    // page row pitch in bytes
    logic                 rd_en;     // address on buf_ra is live
    logic                 rd_first;  // that address starts a macroblock
    logic [5:0]           col;
    logic [5:0]           row;
    logic [9:0]           row_base;  // row * stride
    page_t                rd_page;
    logic [6:0]           mb_x;
    logic                 col_last;
    logic                 row_last;
    strb_t [PIPE_LEN-1:0] strb_q;    // strobes travelling with each address

    assign geom   = cmprs_geometry(frame_cfg.converter_type);
    assign stride = 10'd16 << geom.tile_width;

    assign col_last   = col == geom.mb_w_m1;
    assign row_last   = row == geom.mb_h_m1;
    assign mb_pre_end = rd_en && col_last && row_last;

    assign buf_ra = {rd_page, row_base + {3'b000, mb_x} + {4'b0000, col}};
    assign buf_rd = {strb_q[0].valid, rd_en};

    // address walk, mb_pre_start wins so the next block follows without a gap
    always_ff @(posedge xclk) begin
        if (rst || !frame_en) begin
            rd_en    <= 1'b0;
            rd_first <= 1'b0;
        end else if (mb_pre_start) begin
            rd_en    <= 1'b1;
            rd_first <= 1'b1;
        end else begin
            rd_first <= 1'b0;
            if (mb_pre_end) begin
                rd_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (mb_pre_start) begin
            col      <= '0;
            row      <= '0;
            row_base <= '0;
            rd_page  <= start_page;
            mb_x     <= macroblock_x;
        end else if (rd_en) begin
            if (col_last) begin
                col      <= '0;
                row      <= row + 6'd1;
                row_base <= row_base + stride;  // next page row
            end else begin
                col <= col + 6'd1;
            end
        end
    end

    // strobe delay line, stage k is valid k+1 cycles after its address
    always_ff @(posedge xclk) begin
        if (rst || !frame_en) begin
            strb_q <= '0;
        end else begin
            strb_q[0] <= '{valid: rd_en, first: rd_first};
            for (int k = 1; k < PIPE_LEN; k++) begin
                strb_q[k] <= strb_q[k-1];
            end
        end
    end

    assign pre_first_out = strb_q[BUF_EXTRA_LATENCY].valid && strb_q[BUF_EXTRA_LATENCY].first;
    assign data_valid    = strb_q[BUF_EXTRA_LATENCY+1].valid;

    generate
        if (BUF_EXTRA_LATENCY > 0) begin : g_extra
            pix_t data_q [BUF_EXTRA_LATENCY];  // retiming after the buffer

            always_ff @(posedge xclk) begin
                data_q[0] <= buf_di;
                for (int k = 1; k < BUF_EXTRA_LATENCY; k++) begin
                    data_q[k] <= data_q[k-1];
                end
            end

            assign data_out = data_q[BUF_EXTRA_LATENCY-1];
        end else begin : g_direct
            assign data_out = buf_di;  // buffer output is already registered
        end
    endgenerate

endmodule

// File: jp_channel.sv
`timescale 1ns/1ps

module jp_channel #(
    parameter int BUF_EXTRA_LATENCY = 0  // extra read stages in the pixel reader
) (
    input  logic               xclk,                // compressor clock
    input  logic               rst,
    input  logic               frame_en,            // low aborts the frame
    input  logic               frame_go,            // start a frame when idle
    input  jp_pkg::frame_cfg_t frame_cfg,           // mode and frame size in macroblocks
    input  logic               xfer_reset_page_rd,  // memory side restarts at page 0
    input  logic               buf_wpage_nxt,       // next write page
    input  logic               buf_wr,              // write one word
    input  jp_pkg::buf_word_t  buf_wdata,
    input  logic               page_ready_chn,      // pulse, page is in the buffer
    output logic               next_page_chn,       // pulse, oldest page released
    output jp_pkg::pix_t       mb_data_out,         // macroblock pixels, scanline order
    output logic               mb_pre_first_out,    // one cycle before first pixel
    output logic               mb_data_valid,
    output logic               frame_busy,
    output logic               frame_done
);
    import jp_pkg::*;

    logic       mb_pre_end;    // reader done issuing, next block may start
    logic       mb_pre_start;  // sequencer hands a macroblock to the reader
    page_t      start_page;
    logic [6:0] macroblock_x;  // left column inside the page, up to 127
    buf_addr_t  buf_ra;        // {page, byte}
    logic [1:0] buf_rd;        // {regen, re}
    pix_t       buf_di;

    chn_rd_buf chn_rd_buf_i (
        .xclk         (xclk),
        .rst          (rst),
        .wpage_set    (xfer_reset_page_rd),
        .page_next    (buf_wpage_nxt),
        .we           (buf_wr),
        .data_in      (buf_wdata),
        .ext_ra       (buf_ra),
        .ext_rd       (buf_rd[0]),
        .ext_regen    (buf_rd[1]),
        .ext_data_out (buf_di)
    );

    cmprs_macroblock_buf_iface cmprs_macroblock_buf_iface_i (
        .xclk           (xclk),
        .rst            (rst),
        .frame_en       (frame_en),
        .frame_go       (frame_go),
        .frame_cfg      (frame_cfg),
        .page_ready_chn (page_ready_chn),
        .mb_pre_end     (mb_pre_end),
        .next_page_chn  (next_page_chn),
        .mb_pre_start   (mb_pre_start),
        .start_page     (start_page),
        .macroblock_x   (macroblock_x),
        .frame_busy     (frame_busy),
        .frame_done     (frame_done)
    );

    cmprs_pixel_buf_iface #(
        .BUF_EXTRA_LATENCY (BUF_EXTRA_LATENCY)
    ) cmprs_pixel_buf_iface_i (
        .xclk          (xclk),
        .rst           (rst),
        .frame_en      (frame_en),
        .frame_cfg     (frame_cfg),
        .mb_pre_start  (mb_pre_start),
        .start_page    (start_page),
        .macroblock_x  (macroblock_x),
        .buf_di        (buf_di),
        .buf_ra        (buf_ra),
        .buf_rd        (buf_rd),
        .mb_pre_end    (mb_pre_end),
        .data_out      (mb_data_out),
        .pre_first_out (mb_pre_first_out),
        .data_valid    (mb_data_valid)
    );

endmodule

// File: jp_channel_properties.sv
`timescale 1ns/1ps

module jp_channel_properties (
    input logic xclk,
    input logic rst,
    input logic frame_en,
    input logic next_page_chn,
    input logic frame_done,
    input logic frame_busy,
    input logic mb_pre_first_out,
    input logic mb_data_valid
);

    np_pulse: assert property (@(posedge xclk) disable iff (rst)
        next_page_chn |=> !next_page_chn) else $error("next_page_chn longer than one cycle");

    done_pulse: assert property (@(posedge xclk) disable iff (rst)
        frame_done |=> !frame_done) else $error("frame_done longer than one cycle");

    // abort clears the strobe pipe, so the pairing only holds while enabled
    first_then_valid: assert property (@(posedge xclk) disable iff (rst || !frame_en)
        mb_pre_first_out |=> mb_data_valid) else $error("mb_pre_first_out without data");

    quiet_in_reset: assert property (@(posedge xclk)
        rst |=> !(mb_data_valid || mb_pre_first_out || next_page_chn || frame_done || frame_busy))
        else $error("strobe high during reset");

endmodule

bind jp_channel jp_channel_properties props_i (
    .xclk(xclk), .rst(rst), .frame_en(frame_en), .next_page_chn(next_page_chn),
    .frame_done(frame_done), .frame_busy(frame_busy),
    .mb_pre_first_out(mb_pre_first_out), .mb_data_valid(mb_data_valid)
);

// File: jp_channel_checker.sv
`timescale 1ns/1ps

module jp_channel_checker (
    input  logic               xclk,
    input  logic               rst,
    input  logic               frame_en,
    input  logic               frame_go,
    input  jp_pkg::frame_cfg_t frame_cfg,
    input  logic               xfer_reset_page_rd,
    input  logic               buf_wpage_nxt,
    input  logic               buf_wr,
    input  jp_pkg::buf_word_t  buf_wdata,
    input  logic               page_ready_chn,
    input  logic               next_page_chn,
    input  jp_pkg::pix_t       mb_data_out,
    input  logic               mb_pre_first_out,
    input  logic               mb_data_valid,
    input  logic               frame_busy,
    input  logic               frame_done,
    output int                 error_count
);
    import jp_pkg::*;

    pix_t       model [4096];  // copy of the buffer, byte addressed
    page_t      wpage;
    logic [6:0] wptr;
    mb_geom_t   geom;
    int total, pages, mpp, stride;
    int mb_idx, col, row;      // position of the next expected byte
    int first_cnt, rel_cnt, ready_cnt, done_wait;
    int addr;
    logic active, done_seen;
    logic busy_exp;            // frame_busy expected in this cycle

    task automatic bad_value(input string name, input int exp, input int got);
        $display("Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
        error_count++;
    endtask

    task automatic bad_event(input string msg);
        $display("failure at %0t: %s", $time, msg);
        error_count++;
    endtask

    initial error_count = 0;

    always @(posedge xclk) begin
        if (rst || xfer_reset_page_rd) begin
            wpage = '0;
            wptr  = '0;
        end else if (buf_wpage_nxt) begin
            wpage = wpage + 2'd1;
            wptr  = '0;
        end else if (buf_wr) begin
            for (int i = 0; i < 8; i++) model[{wpage, wptr, 3'(i)}] = buf_wdata[8*i +: 8];
            wptr = wptr + 7'd1;
        end
        if (rst || !frame_en) begin
            active    = 1'b0;
            done_wait = 0;
        end else begin
            if (page_ready_chn) ready_cnt++;
            if (mb_data_valid) begin
                if (!active || mb_idx >= total) begin
                    bad_event("valid byte beyond the frame");
                end else begin
                    addr = ((mb_idx / mpp) % 4) * 1024 + row * stride
                           + (mb_idx % mpp) * int'(geom.mb_hper) + col;
                    if (mb_data_out !== model[addr])
                        bad_value("mb_data_out", model[addr], mb_data_out);
                    col++;
                    if (col > int'(geom.mb_w_m1)) begin
                        col = 0;
                        row++;
                        if (row > int'(geom.mb_h_m1)) begin
                            row = 0;
                            mb_idx++;
                        end
                    end
                end
            end
            // previous macroblock's last byte may land in this same cycle
            if (mb_pre_first_out) begin
                if (!active) bad_event("mb_pre_first_out outside a frame");
                if (col != 0 || row != 0 || first_cnt != mb_idx)
                    bad_event("mb_pre_first_out inside a macroblock");
                if (first_cnt / mpp >= ready_cnt)
                    bad_event("macroblock started before its page was ready");
                first_cnt++;
            end
            if (next_page_chn) begin
                // every macroblock of this page must have been started
                if (first_cnt < (((rel_cnt + 1) * mpp < total) ? (rel_cnt + 1) * mpp : total))
                    bad_event("page released before its last macroblock");
                rel_cnt++;
            end
            if (frame_done) begin
                if (!active || done_seen) bad_event("unexpected frame_done");
                done_seen = 1'b1;
                done_wait = 4;  // last bytes still in the read pipeline
            end else if (done_wait > 0) begin
                done_wait--;
                if (done_wait == 0) begin
                    if (mb_idx != total) bad_value("macroblocks received", total, mb_idx);
                    if (first_cnt != total)
                        bad_value("mb_pre_first_out count", total, first_cnt);
                    if (rel_cnt != pages) bad_value("next_page_chn count", pages, rel_cnt);
                    active = 1'b0;
                end
            end
            if (frame_go && !busy_exp) begin
                geom   = cmprs_geometry(frame_cfg.converter_type);
                mpp    = int'(geom.mb_per_page);
                stride = 16 << geom.tile_width;
                total  = (int'(frame_cfg.n_blocks_in_row_m1) + 1)
                         * (int'(frame_cfg.n_block_rows_m1) + 1);
                pages  = (total + mpp - 1) / mpp;
                {mb_idx, col, row, first_cnt, rel_cnt, ready_cnt} = '0;
                active    = 1'b1;
                done_seen = 1'b0;
            end
        end
        // busy rises after an accepted frame_go, falls after frame_done or abort
        if (!rst && frame_busy !== busy_exp) bad_value("frame_busy", busy_exp, frame_busy);
        if (rst || !frame_en) begin
            busy_exp = 1'b0;
        end else if (frame_done) begin
            busy_exp = 1'b0;
        end else if (frame_go) begin
            busy_exp = 1'b1;
        end
    end

endmodule

// File: tb_jp_channel.sv
`timescale 1ns/1ps

module tb_jp_channel;
    import jp_pkg::*;

    typedef struct packed {
        cmprs_mode_e mode;
        mb_count_t   bx_m1;      // macroblocks per row - 1
        mb_count_t   by_m1;      // macroblock rows - 1
        logic [7:0]  rdy_delay;  // cycles from page write to page_ready_chn
        logic        abort;      // drop frame_en in the middle of the frame
    } frame_row_t;

    localparam int N_ROWS = 8;
    localparam int WAIT_LIMIT = 20000;  // cycles for any single wait

    logic       xclk, rst, frame_en, frame_go;
    frame_cfg_t frame_cfg;
    logic       xfer_reset_page_rd, buf_wpage_nxt, buf_wr, page_ready_chn;
    buf_word_t  buf_wdata;
    logic       next_page_chn, mb_pre_first_out, mb_data_valid, frame_busy, frame_done;
    pix_t       mb_data_out;
    int         chk_errors;
    int         tb_errors;
    int         rel_seen;   // next_page_chn pulses in this frame
    frame_row_t frames [N_ROWS];

    jp_channel #(.BUF_EXTRA_LATENCY(0)) jp_channel_inst (
        .xclk(xclk), .rst(rst), .frame_en(frame_en), .frame_go(frame_go),
        .frame_cfg(frame_cfg), .xfer_reset_page_rd(xfer_reset_page_rd),
        .buf_wpage_nxt(buf_wpage_nxt), .buf_wr(buf_wr), .buf_wdata(buf_wdata),
        .page_ready_chn(page_ready_chn), .next_page_chn(next_page_chn),
        .mb_data_out(mb_data_out), .mb_pre_first_out(mb_pre_first_out),
        .mb_data_valid(mb_data_valid), .frame_busy(frame_busy), .frame_done(frame_done)
    );

    jp_channel_checker checker_i (
        .xclk(xclk), .rst(rst), .frame_en(frame_en), .frame_go(frame_go),
        .frame_cfg(frame_cfg), .xfer_reset_page_rd(xfer_reset_page_rd),
        .buf_wpage_nxt(buf_wpage_nxt), .buf_wr(buf_wr), .buf_wdata(buf_wdata),
        .page_ready_chn(page_ready_chn), .next_page_chn(next_page_chn),
        .mb_data_out(mb_data_out), .mb_pre_first_out(mb_pre_first_out),
        .mb_data_valid(mb_data_valid), .frame_busy(frame_busy), .frame_done(frame_done),
        .error_count(chk_errors)
    );

    initial begin
        xclk = 1'b0;
        forever #50 xclk = ~xclk;  // 100 ns period
    end

    always @(posedge xclk) begin
        if (rst || xfer_reset_page_rd) rel_seen <= 0;
        else if (next_page_chn) rel_seen <= rel_seen + 1;
    end

    // fill one page with random words, announce it after the row's delay
    task automatic write_page(input int delay);
        for (int w = 0; w < 128; w++) begin
            @(posedge xclk);
            buf_wr    <= 1'b1;
            buf_wdata <= {$urandom, $urandom};
        end
        @(posedge xclk);
        buf_wr        <= 1'b0;
        buf_wpage_nxt <= 1'b1;
        @(posedge xclk);
        buf_wpage_nxt <= 1'b0;
        repeat (delay) @(posedge xclk);
        page_ready_chn <= 1'b1;
        @(posedge xclk);
        page_ready_chn <= 1'b0;
    endtask

    // sampled on the falling edge, outputs settled
    task automatic wait_releases(input int need);
        int t;
        t = 0;
        while (rel_seen < need && t < WAIT_LIMIT) begin
            @(negedge xclk);
            t++;
        end
        if (rel_seen < need) begin
            $display("timeout at %0t: page %0d never released", $time, need - 1);
            tb_errors++;
        end
    endtask

    task automatic wait_level(input int which, input logic level, input int limit);
        int t;
        logic v;
        t = 0;
        v = ~level;
        while (v !== level && t < limit) begin
            @(negedge xclk);
            v = (which == 0) ? frame_done : mb_data_valid;
            t++;
        end
        if (v !== level) begin
            $display("timeout at %0t: %s did not reach %b", $time,
                     (which == 0) ? "frame_done" : "mb_data_valid", level);
            tb_errors++;
        end
    endtask

    task automatic run_frame(input frame_row_t fr);
        mb_geom_t g;
        int total, pages;
        g = cmprs_geometry(fr.mode);
        total = (int'(fr.bx_m1) + 1) * (int'(fr.by_m1) + 1);
        pages = (total + int'(g.mb_per_page) - 1) / int'(g.mb_per_page);
        if (fr.abort && pages > 2) pages = 2;  // rest of the frame never arrives
        @(posedge xclk);
        frame_cfg          <= '{fr.mode, fr.bx_m1, fr.by_m1};
        xfer_reset_page_rd <= 1'b1;
        frame_go           <= 1'b1;
        @(posedge xclk);
        xfer_reset_page_rd <= 1'b0;
        frame_go           <= 1'b0;
        for (int p = 0; p < pages; p++) begin
            if (p >= 4) wait_releases(p - 3);  // at most 4 pages ahead
            write_page(fr.rdy_delay);
        end
        if (fr.abort) begin
            wait_level(1, 1'b1, WAIT_LIMIT);
            repeat (5) @(posedge xclk);
            frame_en <= 1'b0;
            wait_level(1, 1'b0, 4);  // must die within a few cycles
            @(posedge xclk);
            frame_en <= 1'b1;
        end else begin
            wait_level(0, 1'b1, WAIT_LIMIT);
        end
        repeat (6) @(posedge xclk);
    endtask

    initial begin
        void'($urandom(69504));
        rst = 1'b1;
        frame_en = 1'b1;
        frame_go = 1'b0;
        frame_cfg = '0;
        xfer_reset_page_rd = 1'b0;
        buf_wpage_nxt = 1'b0;
        buf_wr = 1'b0;
        buf_wdata = '0;
        page_ready_chn = 1'b0;
        tb_errors = 0;
        frames[0] = '{MONO16,  13'd1, 13'd2, 8'd0,   1'b0};
        frames[1] = '{COLOR18, 13'd1, 13'd1, 8'd255, 1'b0};  // pages slower than reads
        frames[2] = '{COLOR20, 13'd2, 13'd1, 8'd3,   1'b0};  // 6 pages, flow control
        frames[3] = '{MONO8,   13'd3, 13'd7, 8'd0,   1'b0};
        frames[4] = '{MONO16,  13'd3, 13'd3, 8'd40,  1'b0};  // slow pages
        frames[5] = '{COLOR18, 13'd3, 13'd2, 8'd0,   1'b1};  // aborted
        frames[6] = '{JP4,     13'd1, 13'd1, 8'd5,   1'b0};
        frames[7] = '{MONO8,   13'd5, 13'd5, 8'd2,   1'b0};
        repeat (2) @(posedge xclk);
        rst <= 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            run_frame(frames[i]);
        end
        $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (400000) @(posedge xclk);
        $display("global timeout at %0t: frames never completed", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: compile.f
jp_pkg.sv
chn_rd_buf.sv
cmprs_macroblock_buf_iface.sv
cmprs_pixel_buf_iface.sv
jp_channel.sv
jp_channel_properties.sv
jp_channel_checker.sv
tb_jp_channel.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_jp_channel \
    -f compile.f -o sim_jp_channel
./obj_dir/sim_jp_channel > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi
exit 0
